// File: src/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

//////////////////////////////
// datapath widths
//////////////////////////////
`define FETCH_XLEN 64 // pc and imem word width
`define FETCH_ILEN 32 // one instruction, half a memory word

//////////////////////////////
// storage depths, powers of two
//////////////////////////////
`define FETCH_IFB_DEPTH 4 // fetch buffer entries
`define FETCH_BTB_ENTRIES 16 // direct mapped btb lines

`define FETCH_RESET_PC 64'h0 // first fetch address out of reset

`define SD // clk to q delay on flop assignments, empty for synthesis

`endif

// File: src/fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

	//////////////////////////////
	// address and instruction
	//////////////////////////////
	typedef logic [`FETCH_XLEN-1:0] pc_t; // byte address
	typedef logic [`FETCH_ILEN-1:0] insn_t; // raw instruction bits

	//////////////////////////////
	// branch direction counter
	//////////////////////////////
	// msb set means predict taken
	// steps move one state toward the outcome and stop at the ends
	typedef enum logic [1:0]
	{
		STRONG_NT = 2'b00, // saturated not taken
		WEAK_NT = 2'b01,
		WEAK_T = 2'b10, // state given to a new entry
		STRONG_T = 2'b11 // saturated taken
	} btb_ctr_e;

	// counter values shared by the predictor and the reference model
	// lookup treats WEAK_T and STRONG_T as taken

endpackage

// File: src/branch_predictor.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module branch_predictor import fetch_pkg::*;
(
	input logic clk,
	input logic rst,

	// lookup side, driven by the fetch pc
	input pc_t fetch_pc_i,
	output logic predict_o, // taken prediction for fetch_pc_i
	output pc_t predict_target_o, // where to go if predict_o

	// resolution side
	input logic update_en_i,
	input pc_t update_pc_i,
	input pc_t update_target_i,
	input logic update_taken_i
);

	localparam int IDX_W = $clog2(`FETCH_BTB_ENTRIES);
	localparam int TAG_W = `FETCH_XLEN - IDX_W - 2; // pc bits above the index

	//////////////////////////////
	// btb storage
	//////////////////////////////
	logic valid_q [`FETCH_BTB_ENTRIES]; // only these bits are reset
	logic [TAG_W-1:0] tag_q [`FETCH_BTB_ENTRIES];
	pc_t target_q [`FETCH_BTB_ENTRIES];
	btb_ctr_e ctr_q [`FETCH_BTB_ENTRIES];

	logic [IDX_W-1:0] look_idx; // lookup index from pc[IDX_W+1:2]
	logic [TAG_W-1:0] look_tag;
	logic look_hit;
	logic [IDX_W-1:0] upd_idx;
	logic [TAG_W-1:0] upd_tag;
	logic upd_hit; // update pc already owns its line

	// one saturating step toward the resolved direction
	function automatic btb_ctr_e ctr_step(input btb_ctr_e cur, input logic taken);
		btb_ctr_e nxt;
		case (cur)
			STRONG_NT: nxt = taken ? WEAK_NT : STRONG_NT;
			WEAK_NT: nxt = taken ? WEAK_T : STRONG_NT;
			WEAK_T: nxt = taken ? STRONG_T : WEAK_NT;
			default: nxt = taken ? STRONG_T : WEAK_T; // STRONG_T
		endcase
		return nxt;
	endfunction

	//////////////////////////////
	// lookup, same cycle
	//////////////////////////////
	assign look_idx = fetch_pc_i[IDX_W+1:2];
	assign look_tag = fetch_pc_i[`FETCH_XLEN-1:IDX_W+2];
	assign look_hit = valid_q[look_idx] && (tag_q[look_idx] == look_tag);

	assign predict_o = look_hit && (ctr_q[look_idx] inside {WEAK_T, STRONG_T});
	assign predict_target_o = target_q[look_idx]; // don't care unless predict_o

	//////////////////////////////
	// update, seen from the next cycle
	//////////////////////////////
	assign upd_idx = update_pc_i[IDX_W+1:2];
	assign upd_tag = update_pc_i[`FETCH_XLEN-1:IDX_W+2];
	assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

	// valid bits, a taken miss claims the line
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `FETCH_BTB_ENTRIES; i++)
				valid_q[i] <= `SD 1'b0;
		end
		else if (update_en_i && !upd_hit && update_taken_i)
			valid_q[upd_idx] <= `SD 1'b1;
	end

	// tag, target and counter payload
	always_ff @(posedge clk)
	begin
		if (update_en_i)
		begin
			if (upd_hit)
			begin
				ctr_q[upd_idx] <= `SD ctr_step(ctr_q[upd_idx], update_taken_i);
				if (update_taken_i)
					target_q[upd_idx] <= `SD update_target_i; // latest taken target wins
			end
			else if (update_taken_i) // allocate, not taken misses are dropped
			begin
				tag_q[upd_idx] <= `SD upd_tag;
				target_q[upd_idx] <= `SD update_target_i;
				ctr_q[upd_idx] <= `SD WEAK_T;
			end
		end
	end

	// counter and tag state never leak x into fetch once out of reset
	a_predict_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(predict_o));

endmodule

// File: src/ifb.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module ifb import fetch_pkg::*;
(
	input logic clk,
	input logic rst,

	// push side from fetch, already gated by if_stage
	input logic ifb_en_i,
	input insn_t if_insn_i,
	input pc_t if_pc_i,
	input pc_t if_target_pc_i, // pc fetched after this one
	input logic bp2if_pred_bit_i,

	input logic flush_en_i, // redirect, drop everything
	input logic decode_en_i, // decode wants the head

	output logic ifb_full_o,
	output logic ifb_empty_o,
	// head entry
	output insn_t ifb_insn_o,
	output pc_t ifb_pc_o,
	output pc_t ifb_target_pc_o,
	output logic ifb_pred_bit_o
);

	localparam int PTR_W = $clog2(`FETCH_IFB_DEPTH);
	localparam int CNT_W = PTR_W + 1; // count reaches DEPTH

	//////////////////////////////
	// entry storage
	//////////////////////////////
	insn_t insn_mem [`FETCH_IFB_DEPTH];
	pc_t pc_mem [`FETCH_IFB_DEPTH];
	pc_t tgt_mem [`FETCH_IFB_DEPTH];
	logic pred_mem [`FETCH_IFB_DEPTH];

	logic [PTR_W-1:0] wr_ptr_q; // next free slot
	logic [PTR_W-1:0] rd_ptr_q; // head slot
	logic [CNT_W-1:0] count_q; // occupancy
	logic push;
	logic pop;

	assign push = ifb_en_i;
	assign pop = decode_en_i && !ifb_empty_o; // pop on empty is ignored

	assign ifb_full_o = (count_q == CNT_W'(`FETCH_IFB_DEPTH));
	assign ifb_empty_o = (count_q == '0);

	//////////////////////////////
	// pointers and count
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst || flush_en_i) // flush beats push and pop
		begin
			wr_ptr_q <= `SD '0;
			rd_ptr_q <= `SD '0;
			count_q <= `SD '0;
		end
		else
		begin
			if (push)
				wr_ptr_q <= `SD wr_ptr_q + PTR_W'(1); // wraps, depth is 2^n
			if (pop)
				rd_ptr_q <= `SD rd_ptr_q + PTR_W'(1);
			count_q <= `SD count_q + CNT_W'(push) - CNT_W'(pop); // both at once keeps count
		end
	end

	// payload write, stale slots are harmless
	always_ff @(posedge clk)
	begin
		if (push)
		begin
			insn_mem[wr_ptr_q] <= `SD if_insn_i;
			pc_mem[wr_ptr_q] <= `SD if_pc_i;
			tgt_mem[wr_ptr_q] <= `SD if_target_pc_i;
			pred_mem[wr_ptr_q] <= `SD bp2if_pred_bit_i;
		end
	end

	//////////////////////////////
	// head to decode
	//////////////////////////////
	assign ifb_insn_o = insn_mem[rd_ptr_q];
	assign ifb_pc_o = pc_mem[rd_ptr_q];
	assign ifb_target_pc_o = tgt_mem[rd_ptr_q];
	assign ifb_pred_bit_o = pred_mem[rd_ptr_q];

	// fetch must hold off while full, this buffer trusts it
	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		ifb_en_i |-> !ifb_full_o);

endmodule

// File: src/if_stage.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module if_stage import fetch_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic bp2if_predict_i, // btb says taken for fetch_pc_o
	input pc_t br_predict_target_pc_i,
	input pc_t br_flush_target_pc_i,
	input logic br_flush_en_i,

	input logic [`FETCH_XLEN-1:0] imem_data_i, // word at imem_addr_o
	input logic imem_valid_i,
	input logic id_request_i,

	output pc_t imem_addr_o, // word aligned fetch address
	output logic imem_req_o,
	output pc_t fetch_pc_o, // full pc, for the btb lookup
	output pc_t if_pc_o,
	output pc_t if_target_pc_o,
	output insn_t if_ir_o,
	output logic if_pred_bit_o,
	output logic if_valid_inst_o // head of buffer is real
);

	pc_t pc_q; // pc being fetched
	pc_t pc_plus_4;
	pc_t next_pc;
	logic pc_en;
	logic ifb_en; // push to buffer
	insn_t if_insn;
	logic ifb_full;
	logic ifb_empty;

	//////////////////////////////
	// memory side
	//////////////////////////////
	assign imem_addr_o = {pc_q[`FETCH_XLEN-1:3], 3'b000};
	assign imem_req_o = !ifb_full || !imem_valid_i;
	assign fetch_pc_o = pc_q;

	// imem returns 64 bits, pc[2] picks the half
	assign if_insn = pc_q[2] ? imem_data_i[63:32] : imem_data_i[31:0];

	//////////////////////////////
	// next pc
	//////////////////////////////
	assign pc_plus_4 = pc_q + pc_t'(4);

	// flush first, then btb, then fall through
	assign next_pc = br_flush_en_i ? br_flush_target_pc_i :
		bp2if_predict_i ? br_predict_target_pc_i : pc_plus_4;

	// accepted fetch only when room and no redirect
	assign ifb_en = imem_valid_i && !ifb_full && !br_flush_en_i;
	assign pc_en = ifb_en || br_flush_en_i; // redirect also moves pc while stalled

	always_ff @(posedge clk)
	begin
		if (rst)
			pc_q <= `SD pc_t'(`FETCH_RESET_PC);
		else if (pc_en)
			pc_q <= `SD next_pc;
	end

	//////////////////////////////
	// fetch buffer
	//////////////////////////////
	ifb ifb0
	(
		.clk(clk),
		.rst(rst),
		.ifb_en_i(ifb_en),
		.if_insn_i(if_insn),
		.if_pc_i(pc_q),
		.if_target_pc_i(next_pc), // flush case never pushed
		.bp2if_pred_bit_i(bp2if_predict_i),
		.flush_en_i(br_flush_en_i),
		.decode_en_i(id_request_i),
		.ifb_full_o(ifb_full),
		.ifb_empty_o(ifb_empty),
		.ifb_insn_o(if_ir_o),
		.ifb_pc_o(if_pc_o),
		.ifb_target_pc_o(if_target_pc_o),
		.ifb_pred_bit_o(if_pred_bit_o)
	);

	assign if_valid_inst_o = !ifb_empty;

	// aligned targets keep the pc on instruction boundaries
	a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
		(pc_q[1:0] == 2'b00)
		&& (!br_flush_en_i || (br_flush_target_pc_i[1:0] == 2'b00))
		&& (!bp2if_predict_i || (br_predict_target_pc_i[1:0] == 2'b00))
		|=> (pc_q[1:0] == 2'b00));

endmodule

// File: src/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_top import fetch_pkg::*;
(
	input logic clk,
	input logic rst,

	//////////////////////////////
	// instruction memory
	//////////////////////////////
	output pc_t imem_addr_o,
	output logic imem_req_o,
	input logic [`FETCH_XLEN-1:0] imem_data_i,
	input logic imem_valid_i, // data matches this cycle's address

	//////////////////////////////
	// decode
	//////////////////////////////
	input logic id_request_i, // pop head
	output logic if_valid_inst_o,
	output pc_t if_pc_o,
	output insn_t if_ir_o,
	output pc_t if_target_pc_o,
	output logic if_pred_bit_o,

	//////////////////////////////
	// redirect and btb training
	//////////////////////////////
	input logic br_flush_en_i,
	input pc_t br_flush_target_i,
	input logic br_update_en_i,
	input pc_t br_update_pc_i,
	input pc_t br_update_target_i,
	input logic br_update_taken_i
);

	pc_t fetch_pc; // if_stage pc into btb lookup
	logic predict; // btb result back into next pc mux
	pc_t predict_target;

	if_stage if_stage0
	(
		.clk(clk),
		.rst(rst),
		.bp2if_predict_i(predict),
		.br_predict_target_pc_i(predict_target),
		.br_flush_target_pc_i(br_flush_target_i),
		.br_flush_en_i(br_flush_en_i),
		.imem_data_i(imem_data_i),
		.imem_valid_i(imem_valid_i),
		.id_request_i(id_request_i),
		.imem_addr_o(imem_addr_o),
		.imem_req_o(imem_req_o),
		.fetch_pc_o(fetch_pc),
		.if_pc_o(if_pc_o),
		.if_target_pc_o(if_target_pc_o),
		.if_ir_o(if_ir_o),
		.if_pred_bit_o(if_pred_bit_o),
		.if_valid_inst_o(if_valid_inst_o)
	);

	// lookup is combinational, same cycle as the fetch
	branch_predictor bp0
	(
		.clk(clk),
		.rst(rst),
		.fetch_pc_i(fetch_pc),
		.predict_o(predict),
		.predict_target_o(predict_target),
		.update_en_i(br_update_en_i),
		.update_pc_i(br_update_pc_i),
		.update_target_i(br_update_target_i),
		.update_taken_i(br_update_taken_i)
	);

endmodule

// File: bench/fetch_checker.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_checker import fetch_pkg::*;
(
	input logic clk,
	input logic rst,
	input pc_t imem_addr_i,
	input logic imem_req_i,
	input logic imem_valid_i,
	input logic id_request_i,
	input logic if_valid_inst_i,
	input pc_t if_pc_i,
	input insn_t if_ir_i,
	input pc_t if_target_pc_i,
	input logic if_pred_bit_i,
	input logic br_flush_en_i,
	input pc_t br_flush_target_i,
	input logic br_update_en_i,
	input pc_t br_update_pc_i,
	input pc_t br_update_target_i,
	input logic br_update_taken_i,
	input logic report_i, // rising edge prints the count line
	output int error_count_o
);

	localparam int IDX_W = $clog2(`FETCH_BTB_ENTRIES);
	localparam pc_t RESET_ADDR = pc_t'(`FETCH_RESET_PC) & ~pc_t'(7); // first word fetched

	typedef struct packed
	{
		pc_t pc;
		pc_t tgt; // pc fetched right after this one
		logic pred;
	} entry_t;

	entry_t exp_q [$]; // expected buffer contents, head first
	logic ref_valid [`FETCH_BTB_ENTRIES]; // reference btb
	pc_t ref_tag [`FETCH_BTB_ENTRIES]; // pc above the index bits
	pc_t ref_target [`FETCH_BTB_ENTRIES];
	btb_ctr_e ref_ctr [`FETCH_BTB_ENTRIES];
	pc_t model_pc; // pc the front end should be fetching
	pc_t last_tgt;
	pc_t flush_pc;
	pc_t held_addr;
	logic seq_ok; // last_tgt is meaningful
	logic flush_pending; // next pop must be the flush target
	logic flushed_prev;
	logic hold_check;
	logic full_now;
	logic req_exp;
	logic rst_prev = 1'b0;
	int errs [string];
	int total = 0;
	string summary;

	assign error_count_o = total;

	// per test counters, all listed in the closing line
	initial
	begin
		errs["reset_state"] = 0;
		errs["insn_select"] = 0;
		errs["pc_sequence"] = 0;
		errs["prediction"] = 0;
		errs["flush_redirect"] = 0;
		errs["backpressure"] = 0;
	end

	task automatic mismatch(input string test, input logic [63:0] exp, input logic [63:0] act);
		errs[test]++;
		total++;
		$display("[ERROR] %s: expected %h, actual %h at %0t", test, exp, act, $time);
	endtask

	// memory word at an aligned address, same rule as the memory model
	function automatic logic [63:0] word_at(input pc_t addr);
		logic [63:0] x;
		x = addr ^ 64'h5a3c_96e1_0f87_d2b4;
		return {x[50:0], x[63:51]}; // rotate left by 13
	endfunction

	function automatic insn_t insn_at(input pc_t pc);
		logic [63:0] w;
		w = word_at({pc[`FETCH_XLEN-1:3], 3'b000});
		return pc[2] ? w[63:32] : w[31:0]; // pc bit 2 picks the half
	endfunction

	task automatic reset_model();
		exp_q.delete();
		for (int i = 0; i < `FETCH_BTB_ENTRIES; i++)
			ref_valid[i] = 1'b0;
		model_pc = pc_t'(`FETCH_RESET_PC);
		seq_ok = 1'b0;
		flush_pending = 1'b0;
		flushed_prev = 1'b0;
		hold_check = 1'b0;
	endtask

	task automatic check_state();
		if (imem_addr_i != {model_pc[`FETCH_XLEN-1:3], 3'b000})
			mismatch("pc_sequence", {model_pc[`FETCH_XLEN-1:3], 3'b000}, imem_addr_i);
		if (hold_check && imem_addr_i != held_addr)
			mismatch("backpressure", held_addr, imem_addr_i); // address moved while full
		if (flushed_prev && if_valid_inst_i)
			mismatch("flush_redirect", 64'(1'b0), 64'(if_valid_inst_i));
		else if (if_valid_inst_i != (exp_q.size() != 0))
			mismatch("backpressure", 64'(exp_q.size() != 0), 64'(if_valid_inst_i));
	endtask

	task automatic check_pop();
		entry_t e;
		e = exp_q.pop_front();
		if (if_ir_i != insn_at(if_pc_i))
			mismatch("insn_select", 64'(insn_at(if_pc_i)), 64'(if_ir_i));
		if (flush_pending && if_pc_i != flush_pc)
			mismatch("flush_redirect", flush_pc, if_pc_i);
		else if (if_pc_i != e.pc)
			mismatch("backpressure", e.pc, if_pc_i); // lost or repeated entry
		if (seq_ok && if_pc_i != last_tgt)
			mismatch("pc_sequence", last_tgt, if_pc_i);
		if (if_pred_bit_i != e.pred)
			mismatch("prediction", 64'(e.pred), 64'(if_pred_bit_i));
		if (if_target_pc_i != e.tgt || (!if_pred_bit_i && if_target_pc_i != if_pc_i + 4))
			mismatch("prediction", e.tgt, if_target_pc_i);
		last_tgt = if_target_pc_i;
		seq_ok = 1'b1;
		flush_pending = 1'b0;
	endtask

	// lookup in the reference btb before this edge's update lands
	task automatic model_fetch();
		logic [IDX_W-1:0] idx;
		entry_t e;
		idx = model_pc[IDX_W+1:2];
		e.pc = model_pc;
		e.pred = ref_valid[idx] && ref_tag[idx] == (model_pc >> (IDX_W + 2))
			&& ref_ctr[idx] >= WEAK_T;
		e.tgt = e.pred ? ref_target[idx] : model_pc + 4;
		exp_q.push_back(e);
		model_pc = e.tgt;
	endtask

	task automatic train(input pc_t pc, input pc_t tgt, input logic taken);
		logic [IDX_W-1:0] idx;
		idx = pc[IDX_W+1:2];
		if (ref_valid[idx] && ref_tag[idx] == (pc >> (IDX_W + 2)))
		begin
			if (taken && ref_ctr[idx] != STRONG_T)
				ref_ctr[idx] = btb_ctr_e'(ref_ctr[idx] + 2'd1);
			else if (!taken && ref_ctr[idx] != STRONG_NT)
				ref_ctr[idx] = btb_ctr_e'(ref_ctr[idx] - 2'd1);
			if (taken)
				ref_target[idx] = tgt;
		end
		else if (taken) // not taken misses leave the line alone
		begin
			ref_valid[idx] = 1'b1;
			ref_tag[idx] = pc >> (IDX_W + 2);
			ref_target[idx] = tgt;
			ref_ctr[idx] = WEAK_T;
		end
	endtask

	//////////////////////////////
	// inputs are stable mid cycle, model the coming edge
	//////////////////////////////
	always @(negedge clk)
	begin
		if (rst)
			reset_model();
		else
		begin
			if (rst_prev)
			begin
				if (if_valid_inst_i)
					mismatch("reset_state", 64'(1'b0), 64'(if_valid_inst_i));
				if (imem_addr_i != RESET_ADDR)
					mismatch("reset_state", RESET_ADDR, imem_addr_i);
			end
			check_state();
			full_now = (exp_q.size() == `FETCH_IFB_DEPTH); // occupancy before the edge
			req_exp = !(full_now && imem_valid_i); // only a full buffer with data waiting stalls
			if (imem_req_i != req_exp)
				mismatch("backpressure", 64'(req_exp), 64'(imem_req_i));
			if (id_request_i && !br_flush_en_i && exp_q.size() != 0)
				check_pop();
			if (imem_valid_i && !full_now && !br_flush_en_i)
				model_fetch();
			hold_check = full_now && !br_flush_en_i;
			held_addr = imem_addr_i;
			flushed_prev = br_flush_en_i;
			if (br_flush_en_i)
			begin
				exp_q.delete();
				model_pc = br_flush_target_i;
				flush_pc = br_flush_target_i;
				flush_pending = 1'b1;
				seq_ok = 1'b0;
			end
			if (br_update_en_i)
				train(br_update_pc_i, br_update_target_i, br_update_taken_i);
		end
		rst_prev = rst;
	end

	always @(posedge report_i)
	begin
		summary = "";
		foreach (errs[t])
			summary = {summary, $sformatf(" %s=%0d", t, errs[t])};
		$display("error counts:%s total=%0d", summary, total);
	end

endmodule

// File: bench/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_tb import fetch_pkg::*;
();

	localparam int STIM_CYCLES = 3000;
	localparam int MAX_CYCLES = STIM_CYCLES + 1000; // reset and drain fit in the margin
	localparam logic [31:0] SEED = 32'hd356_9e06;

	logic clk;
	logic rst;
	logic [`FETCH_XLEN-1:0] imem_data;
	logic imem_valid;
	logic id_request;
	logic br_flush_en;
	pc_t br_flush_target;
	logic br_update_en;
	pc_t br_update_pc;
	pc_t br_update_target;
	logic br_update_taken;
	pc_t imem_addr;
	logic imem_req;
	logic if_valid_inst;
	pc_t if_pc;
	insn_t if_ir;
	pc_t if_target_pc;
	logic if_pred_bit;
	logic report;
	int error_count;
	int cycles = 0;
	int stall; // cycles left with decode held off
	logic [31:0] lfsr;

	fetch_top UUT
	(
		.clk(clk), .rst(rst),
		.imem_addr_o(imem_addr), .imem_req_o(imem_req),
		.imem_data_i(imem_data), .imem_valid_i(imem_valid),
		.id_request_i(id_request), .if_valid_inst_o(if_valid_inst),
		.if_pc_o(if_pc), .if_ir_o(if_ir), .if_target_pc_o(if_target_pc),
		.if_pred_bit_o(if_pred_bit),
		.br_flush_en_i(br_flush_en), .br_flush_target_i(br_flush_target),
		.br_update_en_i(br_update_en), .br_update_pc_i(br_update_pc),
		.br_update_target_i(br_update_target), .br_update_taken_i(br_update_taken)
	);

	fetch_checker chk
	(
		.clk(clk), .rst(rst),
		.imem_addr_i(imem_addr), .imem_req_i(imem_req), .imem_valid_i(imem_valid),
		.id_request_i(id_request), .if_valid_inst_i(if_valid_inst),
		.if_pc_i(if_pc), .if_ir_i(if_ir), .if_target_pc_i(if_target_pc),
		.if_pred_bit_i(if_pred_bit),
		.br_flush_en_i(br_flush_en), .br_flush_target_i(br_flush_target),
		.br_update_en_i(br_update_en), .br_update_pc_i(br_update_pc),
		.br_update_target_i(br_update_target), .br_update_taken_i(br_update_taken),
		.report_i(report), .error_count_o(error_count)
	);

	always #20 clk = ~clk; // 40 ns period

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return r;
	endfunction

	// memory contents, a function of the address alone
	function automatic logic [63:0] word_at(input pc_t addr);
		logic [63:0] x;
		x = addr ^ 64'h5a3c_96e1_0f87_d2b4;
		return {x[50:0], x[63:51]};
	endfunction

	task automatic drive_cycle();
		logic [31:0] r;
		imem_valid = (rand_bits(2) != 0); // about 3 in 4
		if (stall > 0)
		begin
			id_request = 1'b0;
			stall--;
		end
		else if (rand_bits(4) == 0)
		begin
			stall = 6 + int'(rand_bits(3)); // long enough to fill the buffer
			id_request = 1'b0;
		end
		else
			id_request = (rand_bits(1) != 0);
		br_flush_en = (rand_bits(5) == 0);
		r = rand_bits(6);
		br_flush_target = {56'h0, r[5:0], 2'b00}; // 256 byte window
		br_update_en = (rand_bits(3) == 0);
		r = rand_bits(6);
		br_update_pc = {56'h0, r[5:0], 2'b00};
		r = rand_bits(6);
		br_update_target = {56'h0, r[5:0], 2'b00};
		br_update_taken = (rand_bits(1) != 0);
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////
	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		lfsr = SEED;
		stall = 0;
		report = 1'b0;
		imem_data = '0;
		imem_valid = 1'b0;
		id_request = 1'b0;
		br_flush_en = 1'b0;
		br_flush_target = '0;
		br_update_en = 1'b0;
		br_update_pc = '0;
		br_update_target = '0;
		br_update_taken = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		for (int i = 0; i < STIM_CYCLES; i++)
		begin
			drive_cycle();
			imem_data = word_at(imem_addr); // address settled since the edge
			@(posedge clk);
			#2;
		end
		// drain the buffer, no new fetches
		imem_valid = 1'b0;
		br_flush_en = 1'b0;
		br_update_en = 1'b0;
		id_request = 1'b1;
		while (if_valid_inst)
		begin
			@(posedge clk);
			#2;
		end
		report = 1'b1;
		#1;
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

endmodule

// File: tb.f
+incdir+src
src/fetch_pkg.sv
src/branch_predictor.sv
src/ifb.sv
src/if_stage.sv
src/fetch_top.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP ?= fetch_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the fetch testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
